// File: design/sha256_core.sv
`timescale 1ns/100ps
`include "sha_hub_macros.svh"
`default_nettype none

module sha256_core
  import sha256_pkg::*;
(
  input  wire        bus_clk,
  input  wire        rstn_i,
  input  wire        start_i,
  output logic       ready_o,                          // idle or done
  input  wire        fifo_empty_i,
  input  sha_word_t  fifo_data_i,
  output logic       pop_o,
  output logic       hash_valid_o,
  output logic [`SHA_HUB_HASH_WORDS*`SHA_HUB_DATA_W-1:0] hash_o
);

  sha_state_e state_q;
  logic [5:0] cnt_q;                                   // load word / round index
  sha_word_t  h_q [0:`SHA_HUB_HASH_WORDS-1];           // H0 .. H7
  sha_word_t  v_q [0:`SHA_HUB_HASH_WORDS-1];           // working vars a .. h
  sha_word_t  w_q [0:`SHA_HUB_BLOCK_WORDS-1];          // rolling schedule, w_q[0] is W[t]
  sha_word_t  t1;
  sha_word_t  t2;
  sha_word_t  w_new;                                   // W[t+16]
  logic       load_last;

  function automatic sha_word_t rotr(sha_word_t x, int unsigned n);
    return (x >> n) | (x << (`SHA_HUB_DATA_W - n));
  endfunction

  // ----------------------------------------
  // round datapath

  always_comb begin
    t1 = v_q[7] + (rotr(v_q[4], 6) ^ rotr(v_q[4], 11) ^ rotr(v_q[4], 25))
         + ((v_q[4] & v_q[5]) ^ (~v_q[4] & v_q[6]))   // ch(e,f,g)
         + sha_k[cnt_q] + w_q[0];
    t2 = (rotr(v_q[0], 2) ^ rotr(v_q[0], 13) ^ rotr(v_q[0], 22))
         + ((v_q[0] & v_q[1]) ^ (v_q[0] & v_q[2]) ^ (v_q[1] & v_q[2]));  // maj
    w_new = (rotr(w_q[14], 17) ^ rotr(w_q[14], 19) ^ (w_q[14] >> 10)) + w_q[9]
            + (rotr(w_q[1], 7) ^ rotr(w_q[1], 18) ^ (w_q[1] >> 3)) + w_q[0];
  end

  assign pop_o     = (state_q == ST_LOAD) & ~fifo_empty_i;   // stall while FIFO is dry
  assign load_last = pop_o & (cnt_q == 6'(`SHA_HUB_BLOCK_WORDS - 1));

  generate
    for (genvar i = 0; i < `SHA_HUB_HASH_WORDS; i++) begin : g_hash
      assign hash_o[(`SHA_HUB_HASH_WORDS-1-i)*`SHA_HUB_DATA_W +: `SHA_HUB_DATA_W] = h_q[i];
    end
  endgenerate

  // ----------------------------------------
  // control FSM

  always_ff @(posedge bus_clk) begin
    if (!rstn_i) begin
      state_q      <= ST_IDLE;
      cnt_q        <= '0;
      ready_o      <= 1'b0;
      hash_valid_o <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE, ST_DONE: begin
          ready_o <= ~start_i;
          if (start_i) begin
            state_q      <= ST_LOAD;
            cnt_q        <= '0;
            hash_valid_o <= 1'b0;                      // result dropped on a new message
          end
        end
        ST_LOAD: begin
          if (load_last) begin
            state_q <= ST_ROUND;
            cnt_q   <= '0;
          end else if (pop_o) begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        ST_ROUND: begin
          if (cnt_q == 6'(`SHA_HUB_ROUNDS - 1)) state_q <= ST_ADD;
          cnt_q <= cnt_q + 1'b1;                       // wraps to 0 after round 63
        end
        ST_ADD: begin
          cnt_q <= '0;
          if (!fifo_empty_i) begin
            state_q <= ST_LOAD;                        // next block of the message
          end else begin
            state_q      <= ST_DONE;
            hash_valid_o <= 1'b1;
            ready_o      <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // hash, working vars and schedule

  always_ff @(posedge bus_clk) begin
    case (state_q)
      ST_IDLE, ST_DONE: begin
        if (start_i) h_q <= sha_h_init;
      end
      ST_LOAD: begin
        if (pop_o) begin
          for (int i = 0; i < `SHA_HUB_BLOCK_WORDS - 1; i++) w_q[i] <= w_q[i+1];
          w_q[`SHA_HUB_BLOCK_WORDS-1] <= fifo_data_i;  // message words enter at the top
        end
        if (load_last) v_q <= h_q;                     // a..h from current H
      end
      ST_ROUND: begin
        for (int i = 0; i < `SHA_HUB_BLOCK_WORDS - 1; i++) w_q[i] <= w_q[i+1];
        w_q[`SHA_HUB_BLOCK_WORDS-1] <= w_new;
        v_q[0] <= t1 + t2;
        v_q[1] <= v_q[0];
        v_q[2] <= v_q[1];
        v_q[3] <= v_q[2];
        v_q[4] <= v_q[3] + t1;
        v_q[5] <= v_q[4];
        v_q[6] <= v_q[5];
        v_q[7] <= v_q[6];
      end
      ST_ADD: begin
        for (int i = 0; i < `SHA_HUB_HASH_WORDS; i++) h_q[i] <= h_q[i] + v_q[i];
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: design/sha256_pkg.sv
`include "sha_hub_macros.svh"
`default_nettype none

package sha256_pkg;

  typedef logic [`SHA_HUB_DATA_W-1:0] sha_word_t;

  // engine FSM
  typedef enum logic [2:0] {
    ST_IDLE,                       // waiting for start
    ST_LOAD,                       // fill schedule from FIFO
    ST_ROUND,                      // 64 compression rounds
    ST_ADD,                        // fold working vars into H
    ST_DONE                        // hash valid, waiting for start
  } sha_state_e;

  // ----------------------------------------
  // round constants K[0..63]
  parameter sha_word_t sha_k [0:`SHA_HUB_ROUNDS-1] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // initial hash, H0 first
  parameter sha_word_t sha_h_init [0:`SHA_HUB_HASH_WORDS-1] = '{
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

endpackage

`default_nettype wire

// File: design/sha_hub_macros.svh
`ifndef SHA_HUB_MACROS_SVH
`define SHA_HUB_MACROS_SVH

`default_nettype none

// ----------------------------------------
// bus geometry

`define SHA_HUB_DATA_W       32            // bus data width
`define SHA_HUB_ADDR_W       20            // decoded address bits

// ----------------------------------------
// message FIFO

`define SHA_HUB_FIFO_DEPTH   32            // FIFO entries
`define SHA_HUB_FIFO_CNT_W   6             // count holds 0 .. depth

// ----------------------------------------
// hash geometry

`define SHA_HUB_HASH_WORDS   8             // H0 .. H7
`define SHA_HUB_BLOCK_WORDS  16            // 512 bit block
`define SHA_HUB_ROUNDS       64            // compression rounds

// version word, major / minor / build
`define SHA_HUB_VERSION      32'h0201_0003

`default_nettype wire

`endif

// File: design/sha_hub_reg_pkg.sv
`include "sha_hub_macros.svh"
`default_nettype none

package sha_hub_reg_pkg;

  // byte addresses seen on the system bus
  typedef enum logic [`SHA_HUB_ADDR_W-1:0] {
    REG_CTRL         = 20'h00000,  // hub control, rw
    REG_STATUS       = 20'h00004,  // hub status, ro
    REG_VERSION      = 20'h0000C,  // version word, ro
    REG_SHA_CTRL     = 20'h00100,  // engine control, rw
    REG_SHA_STATUS   = 20'h00104,  // engine status, ro
    REG_SHA_PUSH     = 20'h0010C,  // message word push, wo
    REG_SHA_HASH_H7  = 20'h00110,  // least significant hash word
    REG_SHA_HASH_H6  = 20'h00114,
    REG_SHA_HASH_H5  = 20'h00118,
    REG_SHA_HASH_H4  = 20'h0011C,
    REG_SHA_HASH_H3  = 20'h00120,
    REG_SHA_HASH_H2  = 20'h00124,
    REG_SHA_HASH_H1  = 20'h00128,
    REG_SHA_HASH_H0  = 20'h0012C,  // most significant hash word
    REG_SHA_FIFO_CNT = 20'h00130   // FIFO occupancy, ro
  } reg_addr_e;

  // REG_CTRL bit positions
  typedef enum int unsigned {
    CTRL_ENABLE = 0                // hub enable
  } ctrl_bit_e;

  // REG_SHA_CTRL bit positions
  typedef enum int unsigned {
    SHA_CTRL_ENABLE = 0,           // engine enable
    SHA_CTRL_RESET  = 1            // one-shot, clears itself
  } sha_ctrl_bit_e;

endpackage

`default_nettype wire

// File: design/sha_hub_regs.sv
`timescale 1ns/100ps
`include "sha_hub_macros.svh"
`default_nettype none

module sha_hub_regs
  import sha_hub_reg_pkg::*;
  import sha256_pkg::*;
(
  input  wire                          bus_clk,
  input  wire                          bus_rstn,
  input  wire [`SHA_HUB_ADDR_W-1:0]    sys_addr_i,
  input  sha_word_t                    sys_wdata_i,
  input  wire                          sys_wen_i,
  input  wire                          sys_ren_i,
  output sha_word_t                    sys_rdata_o,
  output logic                         sys_ack_o,
  output logic                         hub_enabled_o,
  output logic                         push_o,          // one word into the FIFO
  output sha_word_t                    push_data_o,
  input  wire [`SHA_HUB_FIFO_CNT_W-1:0] fifo_count_i,
  input  wire                          fifo_empty_i,
  input  wire                          fifo_afull_i,
  input  wire                          fifo_full_i,
  output logic                         eng_rstn_o,      // gated engine reset
  output logic                         start_o,         // one-cycle start pulse
  input  wire                          ready_i,
  input  wire                          hash_valid_i,
  input  wire [`SHA_HUB_HASH_WORDS*`SHA_HUB_DATA_W-1:0] hash_i
);

  sha_word_t  ctrl_q;                                   // REG_CTRL
  sha_word_t  sha_ctrl_q;                               // REG_SHA_CTRL
  sha_word_t  hash_q [0:`SHA_HUB_HASH_WORDS-1];         // index 0 is H7 at 0x110
  logic       hash_valid_q;                             // edge detect
  logic [2:0] hash_idx;
  sha_word_t  status_w;
  sha_word_t  sha_status_w;
  sha_word_t  rd_data;

  assign hub_enabled_o = ctrl_q[CTRL_ENABLE];

  // ----------------------------------------
  // bus writes

  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      ctrl_q     <= '0;
      sha_ctrl_q <= '0;
      push_o     <= 1'b0;
    end else begin
      sha_ctrl_q[SHA_CTRL_RESET] <= 1'b0;               // one-shot drops after a cycle
      push_o <= 1'b0;
      if (sys_wen_i) begin
        case (sys_addr_i)
          REG_CTRL:     ctrl_q <= sys_wdata_i;
          REG_SHA_CTRL: sha_ctrl_q <= sys_wdata_i;
          REG_SHA_PUSH: push_o <= 1'b1;                 // full FIFO drops it
          default: ;                                    // ro or unmapped, ignored
        endcase
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (sys_wen_i && sys_addr_i == REG_SHA_PUSH) begin
      push_data_o <= sys_wdata_i;
    end
  end

  // ----------------------------------------
  // engine reset and auto start

  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      eng_rstn_o <= 1'b0;
    end else begin
      eng_rstn_o <= ctrl_q[CTRL_ENABLE] & sha_ctrl_q[SHA_CTRL_ENABLE]
                    & ~sha_ctrl_q[SHA_CTRL_RESET];
    end
  end

  // start once data waits and the engine sits idle without a pending result
  always_ff @(posedge bus_clk) begin
    if (!eng_rstn_o) begin
      start_o <= 1'b0;
    end else begin
      start_o <= ~fifo_empty_i & ready_i & ~hash_valid_i & ~start_o;
    end
  end

  // hash capture on rising edge of valid
  always_ff @(posedge bus_clk) begin
    if (!eng_rstn_o) begin
      hash_valid_q <= 1'b0;
      for (int i = 0; i < `SHA_HUB_HASH_WORDS; i++) begin
        hash_q[i] <= '0;
      end
    end else begin
      hash_valid_q <= hash_valid_i;
      if (hash_valid_i && !hash_valid_q) begin
        for (int i = 0; i < `SHA_HUB_HASH_WORDS; i++) begin
          hash_q[i] <= hash_i[i*`SHA_HUB_DATA_W +: `SHA_HUB_DATA_W];  // H7 sits in the low word
        end
      end
    end
  end

  // ----------------------------------------
  // read mux

  assign hash_idx     = sys_addr_i[4:2] - 3'd4;         // 0x110 -> 0, 0x12C -> 7
  assign status_w     = {27'b0, eng_rstn_o, 3'b0, ctrl_q[CTRL_ENABLE]};
  assign sha_status_w = {25'b0, fifo_full_i, fifo_afull_i, fifo_empty_i,
                         2'b0, hash_valid_i, ready_i};

  always_comb begin
    rd_data = '0;                                       // unmapped reads return zero
    case (sys_addr_i)
      REG_CTRL:         rd_data = ctrl_q;
      REG_STATUS:       rd_data = status_w;
      REG_VERSION:      rd_data = `SHA_HUB_VERSION;
      REG_SHA_CTRL:     rd_data = sha_ctrl_q;
      REG_SHA_STATUS:   rd_data = sha_status_w;
      REG_SHA_HASH_H7, REG_SHA_HASH_H6, REG_SHA_HASH_H5, REG_SHA_HASH_H4,
      REG_SHA_HASH_H3, REG_SHA_HASH_H2, REG_SHA_HASH_H1, REG_SHA_HASH_H0:
        rd_data = hash_q[hash_idx];
      REG_SHA_FIFO_CNT:
        rd_data = {{(`SHA_HUB_DATA_W-`SHA_HUB_FIFO_CNT_W){1'b0}}, fifo_count_i};
      default: ;
    endcase
  end

  // ack every strobe, one cycle later
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      sys_ack_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
      if (sys_ren_i) begin
        sys_rdata_o <= rd_data;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/sha_hub_top.sv
`timescale 1ns/100ps
`include "sha_hub_macros.svh"
`default_nettype none

module sha_hub_top
  import sha256_pkg::*;
(
  input  wire                       bus_clk,
  input  wire                       bus_rstn,        // sync, active low
  input  wire [`SHA_HUB_ADDR_W-1:0] sys_addr_i,
  input  sha_word_t                 sys_wdata_i,
  input  wire                       sys_wen_i,       // write strobe
  input  wire                       sys_ren_i,       // read strobe
  output sha_word_t                 sys_rdata_o,
  output logic                      sys_ack_o,
  output logic                      hub_enabled_o
);

  // FIFO link
  logic                          push;
  sha_word_t                     push_data;
  logic                          pop;
  sha_word_t                     fifo_data;
  logic [`SHA_HUB_FIFO_CNT_W-1:0] fifo_count;
  logic                          fifo_empty;
  logic                          fifo_afull;
  logic                          fifo_full;

  // engine link
  logic                          eng_rstn;         // gated reset for FIFO and core
  logic                          start;
  logic                          ready;
  logic                          hash_valid;
  logic [`SHA_HUB_HASH_WORDS*`SHA_HUB_DATA_W-1:0] hash;

  sha_hub_regs i_regs (
    .bus_clk       (bus_clk),
    .bus_rstn      (bus_rstn),
    .sys_addr_i    (sys_addr_i),
    .sys_wdata_i   (sys_wdata_i),
    .sys_wen_i     (sys_wen_i),
    .sys_ren_i     (sys_ren_i),
    .sys_rdata_o   (sys_rdata_o),
    .sys_ack_o     (sys_ack_o),
    .hub_enabled_o (hub_enabled_o),
    .push_o        (push),
    .push_data_o   (push_data),
    .fifo_count_i  (fifo_count),
    .fifo_empty_i  (fifo_empty),
    .fifo_afull_i  (fifo_afull),
    .fifo_full_i   (fifo_full),
    .eng_rstn_o    (eng_rstn),
    .start_o       (start),
    .ready_i       (ready),
    .hash_valid_i  (hash_valid),
    .hash_i        (hash)
  );

  word_fifo i_fifo (
    .bus_clk     (bus_clk),
    .rstn_i      (eng_rstn),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .fifo_data_o (fifo_data),
    .count_o     (fifo_count),
    .empty_o     (fifo_empty),
    .afull_o     (fifo_afull),
    .full_o      (fifo_full)
  );

  sha256_core i_core (
    .bus_clk      (bus_clk),
    .rstn_i       (eng_rstn),
    .start_i      (start),
    .ready_o      (ready),
    .fifo_empty_i (fifo_empty),
    .fifo_data_i  (fifo_data),
    .pop_o        (pop),
    .hash_valid_o (hash_valid),
    .hash_o       (hash)
  );

endmodule

`default_nettype wire

// File: design/word_fifo.sv
`timescale 1ns/100ps
`include "sha_hub_macros.svh"
`default_nettype none

module word_fifo
  import sha256_pkg::*;
(
  input  wire                           bus_clk,
  input  wire                           rstn_i,       // gated engine reset
  input  wire                           push_i,
  input  sha_word_t                     push_data_i,
  input  wire                           pop_i,
  output sha_word_t                     fifo_data_o,  // head word, valid when not empty
  output logic [`SHA_HUB_FIFO_CNT_W-1:0] count_o,
  output logic                          empty_o,
  output logic                          afull_o,      // one slot left
  output logic                          full_o
);

  localparam int PTR_W = `SHA_HUB_FIFO_CNT_W - 1;

  sha_word_t        mem [0:`SHA_HUB_FIFO_DEPTH-1];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i & ~full_o;                  // overflow drops the word
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge bus_clk) begin
    if (!rstn_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_o  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;       // pointers wrap at depth
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      count_o <= count_o + {{PTR_W{1'b0}}, do_push} - {{PTR_W{1'b0}}, do_pop};
    end
  end

  always_ff @(posedge bus_clk) begin
    if (do_push) mem[wr_ptr_q] <= push_data_i;
  end

  assign fifo_data_o = mem[rd_ptr_q];
  assign empty_o     = (count_o == '0);
  assign full_o      = (count_o == `SHA_HUB_FIFO_CNT_W'(`SHA_HUB_FIFO_DEPTH));
  assign afull_o     = (count_o == `SHA_HUB_FIFO_CNT_W'(`SHA_HUB_FIFO_DEPTH - 1));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the SHA hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f tb.f --top-module tb_sha_hub -Mdir obj_dir -o tb_sha_hub
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sha_hub > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tb.f
+incdir+design
design/sha_hub_reg_pkg.sv
design/sha256_pkg.sv
design/word_fifo.sv
design/sha256_core.sv
design/sha_hub_regs.sv
design/sha_hub_top.sv
verification/tb_sha_hub.sv

// File: verification/tb_sha_hub.sv
`timescale 1ns/100ps
`include "sha_hub_macros.svh"
`default_nettype none

module tb_sha_hub
  import sha_hub_reg_pkg::*;
  import sha256_pkg::*;
();

  localparam int MAX_ROWS   = 160;
  localparam int ACK_LIMIT  = 8;                        // cycles to wait for sys_ack
  localparam int POLL_LIMIT = 400;                      // cycles to wait for hash valid
  localparam int ROW_CYCLES = 400;                      // timeout budget per row

  typedef enum logic [1:0] {
    OP_WR,                                              // bus write
    OP_RD,                                              // bus read and compare
    OP_WAIT_VALID                                       // poll until hash valid
  } tb_op_e;

  logic                       bus_clk;
  logic                       bus_rstn;
  logic [`SHA_HUB_ADDR_W-1:0] sys_addr;
  sha_word_t                  sys_wdata;
  logic                       sys_wen;
  logic                       sys_ren;
  sha_word_t                  sys_rdata;
  logic                       sys_ack;
  logic                       hub_enabled;

  // stimulus table
  tb_op_e                     tbl_op   [0:MAX_ROWS-1];
  logic [`SHA_HUB_ADDR_W-1:0] tbl_addr [0:MAX_ROWS-1];
  sha_word_t                  tbl_data [0:MAX_ROWS-1];  // write data or expected read
  string                      tbl_name [0:MAX_ROWS-1];
  int                         n_rows        = 0;

  int                         n_checks      = 0;
  int                         value_errors  = 0;
  int                         other_errors  = 0;
  int                         cycle_cnt     = 0;
  int                         timeout_limit = 0;

  sha_hub_top dut (
    .bus_clk       (bus_clk),
    .bus_rstn      (bus_rstn),
    .sys_addr_i    (sys_addr),
    .sys_wdata_i   (sys_wdata),
    .sys_wen_i     (sys_wen),
    .sys_ren_i     (sys_ren),
    .sys_rdata_o   (sys_rdata),
    .sys_ack_o     (sys_ack),
    .hub_enabled_o (hub_enabled)
  );

  always #20 bus_clk = ~bus_clk;                        // 40 ns period

  // ----------------------------------------
  // table building

  task automatic add_row(input tb_op_e op, input logic [`SHA_HUB_ADDR_W-1:0] addr,
                         input sha_word_t data, input string name);
    if (n_rows >= MAX_ROWS) begin
      other_errors++;
      $display("stimulus table is full, row %s left out", name);
    end else begin
      tbl_op[n_rows]   = op;
      tbl_addr[n_rows] = addr;
      tbl_data[n_rows] = data;
      tbl_name[n_rows] = name;
      n_rows++;
    end
  endtask

  // pad a message by the SHA-256 rules and push it word by word
  task automatic add_message(input string name, input string msg);
    int          len;
    int          total;
    int          b;
    logic [63:0] len_bits;
    logic [7:0]  b_v;
    sha_word_t   w;
    len      = msg.len();
    total    = ((len + 8) / 64 + 1) * 64;               // bytes after padding
    len_bits = 64'(len) * 64'd8;
    for (int wi = 0; wi < total / 4; wi++) begin
      w = '0;
      for (int k = 0; k < 4; k++) begin
        b = 4 * wi + k;
        if (b < len) b_v = msg[b];
        else if (b == len) b_v = 8'h80;                 // end marker
        else if (b >= total - 8) b_v = len_bits[8*(total-1-b) +: 8];  // big endian length
        else b_v = 8'h00;
        w = {w[23:0], b_v};
      end
      add_row(OP_WR, REG_SHA_PUSH, w, $sformatf("%s push %0d", name, wi));
    end
  endtask

  // h holds H0 in the top word
  task automatic add_hash_reads(input string name, input logic [255:0] h);
    for (int i = 0; i < `SHA_HUB_HASH_WORDS; i++) begin
      add_row(OP_RD, 20'(REG_SHA_HASH_H0) - 20'(4 * i), h[255-32*i -: 32],
              $sformatf("%s H%0d", name, i));
    end
  endtask

  // ----------------------------------------
  // bus access

  task automatic wait_ack(input string name, output logic ok);
    int waited;
    ok     = 1'b0;
    waited = 0;
    while (!ok && waited < ACK_LIMIT) begin
      @(negedge bus_clk);                               // outputs settled mid cycle
      waited++;
      if (sys_ack) ok = 1'b1;
    end
    if (!ok) begin
      other_errors++;
      $display("%s: no bus ack within %0d cycles", name, ACK_LIMIT);
    end
  endtask

  task automatic bus_write(input logic [`SHA_HUB_ADDR_W-1:0] addr, input sha_word_t data,
                           input string name);
    logic ok;
    @(posedge bus_clk);
    sys_addr  <= addr;
    sys_wdata <= data;
    sys_wen   <= 1'b1;
    @(posedge bus_clk);
    sys_wen   <= 1'b0;                                  // one-cycle strobe
    wait_ack(name, ok);
  endtask

  task automatic bus_read(input logic [`SHA_HUB_ADDR_W-1:0] addr, input string name,
                          output sha_word_t data, output logic ok);
    @(posedge bus_clk);
    sys_addr <= addr;
    sys_ren  <= 1'b1;
    @(posedge bus_clk);
    sys_ren  <= 1'b0;
    wait_ack(name, ok);
    data = sys_rdata;                                   // valid with the ack
  endtask

  task automatic wait_hash_valid(input string name);
    int        start_cycle;
    sha_word_t st;
    logic      ok;
    logic      seen;
    start_cycle = cycle_cnt;
    seen        = 1'b0;
    ok          = 1'b1;
    while (!seen && ok && (cycle_cnt - start_cycle) < POLL_LIMIT) begin
      bus_read(REG_SHA_STATUS, name, st, ok);
      if (ok && st[1]) seen = 1'b1;                     // status bit 1 is hash valid
    end
    if (ok && !seen) begin
      other_errors++;
      $display("%s: hash valid never came up within %0d cycles", name, POLL_LIMIT);
    end
  endtask

  // hub_enabled_o follows bit 0 of the last REG_CTRL write
  task automatic check_hub_enable(input string name, input logic exp_en);
    n_checks++;
    if (hub_enabled !== exp_en) begin
      value_errors++;
      $display("Fail %s hub enable: expected %0b, actual %0b",
               name, exp_en, hub_enabled);
    end
  endtask

  task automatic print_counts();
    $display("checks %0d, value errors %0d, other errors %0d",
             n_checks, value_errors, other_errors);
  endtask

  // ----------------------------------------
  // timeout

  always @(posedge bus_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
      other_errors++;
      $display("run stopped by timeout after %0d cycles", cycle_cnt);
      print_counts();
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ----------------------------------------
  // main sequence

  initial begin
    sha_word_t rdata;
    logic      ok;
    logic      exp_hub_en;
    int        gap;
    bus_clk    = 1'b0;
    bus_rstn   = 1'b0;
    sys_addr   = '0;
    sys_wdata  = '0;
    sys_wen    = 1'b0;
    sys_ren    = 1'b0;
    exp_hub_en = 1'b0;                                  // hub off after reset
    void'($urandom(87214));

    // reset values
    add_row(OP_RD, REG_CTRL,     32'h0, "reset ctrl");
    add_row(OP_RD, REG_STATUS,   32'h0, "reset status");
    add_row(OP_RD, REG_SHA_CTRL, 32'h0, "reset sha ctrl");
    add_row(OP_RD, REG_VERSION,  `SHA_HUB_VERSION, "version");
    add_row(OP_RD, 20'h00200,    32'h0, "unmapped read");
    add_row(OP_WR, REG_VERSION,  32'hffff_ffff, "version write");
    add_row(OP_RD, REG_VERSION,  `SHA_HUB_VERSION, "version read only");
    // enable hub and engine, reset bit clears itself
    add_row(OP_WR, REG_CTRL,       32'h1,  "enable hub");
    add_row(OP_WR, REG_SHA_CTRL,   32'h3,  "enable engine");
    add_row(OP_RD, REG_SHA_CTRL,   32'h1,  "sha ctrl self clear");
    add_row(OP_RD, REG_STATUS,     32'h11, "status enabled");
    add_row(OP_RD, REG_SHA_STATUS, 32'h11, "sha status idle");
    // one block
    add_message("abc", "abc");
    add_row(OP_WAIT_VALID, REG_SHA_STATUS, 32'h0, "abc wait");
    add_hash_reads("abc",
                   256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad);
    // one-shot reset, then two blocks
    add_row(OP_WR, REG_SHA_CTRL, 32'h3, "one-shot reset");
    add_row(OP_RD, REG_SHA_CTRL, 32'h1, "sha ctrl after reset");
    add_hash_reads("cleared", 256'h0);
    add_row(OP_RD, REG_SHA_FIFO_CNT, 32'h0, "fifo count cleared");
    add_message("two block", "abcdbcdecdefdefgefghfghighijhijkijkljklmklmnlmnomnopnopq");
    add_row(OP_WAIT_VALID, REG_SHA_STATUS, 32'h0, "two block wait");
    add_hash_reads("two block",
                   256'h248d6a61_d20638b8_e5c02693_0c3e6039_a33ce459_64ff2167_f6ecedd4_19db06c1);
    // hub disable gates the engine
    add_row(OP_WR, REG_CTRL,       32'h0,  "disable hub");
    add_row(OP_RD, REG_STATUS,     32'h0,  "status disabled");
    add_hash_reads("disabled", 256'h0);
    add_row(OP_RD, REG_SHA_STATUS, 32'h10, "sha status not ready");
    add_row(OP_WR, REG_CTRL,       32'h1,  "re-enable hub");
    add_message("empty", "");
    add_row(OP_WAIT_VALID, REG_SHA_STATUS, 32'h0, "empty wait");
    add_hash_reads("empty",
                   256'he3b0c442_98fc1c14_9afbf4c8_996fb924_27ae41e4_649b934c_a495991b_7852b855);

    timeout_limit = n_rows * ROW_CYCLES + 100;

    repeat (4) @(posedge bus_clk);
    bus_rstn <= 1'b1;

    for (int r = 0; r < n_rows; r++) begin
      gap = $urandom % 4;                               // idle cycles between rows
      repeat (gap) @(posedge bus_clk);
      case (tbl_op[r])
        OP_WR: begin
          bus_write(tbl_addr[r], tbl_data[r], tbl_name[r]);
          if (tbl_addr[r] == REG_CTRL) exp_hub_en = tbl_data[r][CTRL_ENABLE];
        end
        OP_RD: begin
          bus_read(tbl_addr[r], tbl_name[r], rdata, ok);
          if (ok) begin
            n_checks++;
            if (rdata !== tbl_data[r]) begin
              value_errors++;
              $display("Fail %s: expected 0x%08h, actual 0x%08h",
                       tbl_name[r], tbl_data[r], rdata);
            end
          end
        end
        default: wait_hash_valid(tbl_name[r]);
      endcase
      check_hub_enable(tbl_name[r], exp_hub_en);        // sampled mid cycle after the ack
    end

    repeat (2) @(posedge bus_clk);
    print_counts();
    if (value_errors + other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
